//--- xbar.f
+incdir+src
src/xbar_pkg.sv
src/xbar_addr_decode.sv
src/xbar_rr_arbiter.sv
src/xbar_write_path.sv
src/xbar_read_path.sv
src/xbar_wrap.sv
tb/xbar_slave_model.sv
tb/xbar_checker.sv
tb/tb_xbar.sv

//--- Makefile
# Verilator build and run of the crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_xbar
FILELIST  ?= xbar.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_xbar.sv
// top of the crossbar testbench, runs three random masters against five slave models
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module tb_xbar
	import xbar_pkg::*;
();

	localparam int TIMEOUT = 2000;
	localparam logic [63:0] BASES [`XBAR_NUM_S] = '{
		`XBAR_S0_BASE, `XBAR_S1_BASE, `XBAR_S2_BASE, `XBAR_S3_BASE, `XBAR_S4_BASE
	};

	logic                      aclk, rst_n;
	axi_aw_t [`XBAR_NUM_M-1:0] m_aw;
	axi_w_t  [`XBAR_NUM_M-1:0] m_w;
	axi_ar_t [`XBAR_NUM_M-1:0] m_ar;
	logic    [`XBAR_NUM_M-1:0] m_bready, m_rready;
	wire     [`XBAR_NUM_M-1:0] m_awready, m_wready, m_arready;
	wire axi_b_t  [`XBAR_NUM_M-1:0] m_b;
	wire axi_r_t  [`XBAR_NUM_M-1:0] m_r;
	wire axi_aw_t [`XBAR_NUM_S-1:0] s_aw;
	wire axi_w_t  [`XBAR_NUM_S-1:0] s_w;
	wire axi_ar_t [`XBAR_NUM_S-1:0] s_ar;
	wire     [`XBAR_NUM_S-1:0] s_bready, s_rready, s_awready, s_wready, s_arready;
	wire axi_b_t  [`XBAR_NUM_S-1:0] s_b;
	wire axi_r_t  [`XBAR_NUM_S-1:0] s_r;

	logic [`XBAR_NUM_S-1:0] stall_ar;
	logic [`XBAR_NUM_M-1:0] bp_en;       // random bready/rready per master
	logic                   err_phase, rd_pending;
	logic [31:0]            rnd;
	int                     chk_errors, fails;

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	xbar_wrap i_dut (
		.aclk, .rst_n, .m_aw, .m_w, .m_ar, .m_bready, .m_rready,
		.m_awready, .m_wready, .m_arready, .m_b, .m_r,
		.s_aw, .s_w, .s_ar, .s_bready, .s_rready,
		.s_awready, .s_wready, .s_arready, .s_b, .s_r
	);

	for (genvar s = 0; s < `XBAR_NUM_S; s++) begin : g_slv
		xbar_slave_model #(.SLV(s)) i_slv (
			.aclk, .rst_n, .stall_ar (stall_ar[s]),
			.aw (s_aw[s]), .w (s_w[s]), .ar (s_ar[s]),
			.bready (s_bready[s]), .rready (s_rready[s]),
			.awready (s_awready[s]), .wready (s_wready[s]), .arready (s_arready[s]),
			.b (s_b[s]), .r (s_r[s])
		);
	end

	xbar_checker i_chk (
		.aclk, .rst_n, .err_phase, .m_aw, .m_w, .m_ar, .m_bready, .m_rready,
		.m_awready, .m_wready, .m_arready, .m_b, .m_r, .s_aw, .s_w, .s_ar,
		.errors (chk_errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw();
		rnd = xorshift(rnd);
		return rnd;
	endfunction

	function automatic logic ready_draw(input int m);
		return bp_en[m] ? 1'(draw()) : 1'b1;
	endfunction

	// each master owns words m*8 .. m*8+7 of every slave
	function automatic logic [63:0] word_addr(input int s, input int m, input int k);
		return BASES[s] + 64'((m * 8 + k) * 8);
	endfunction

	task automatic do_write(input int m, input logic [63:0] a, input logic [63:0] d,
	                        input logic [7:0] st);
		int   n;
		logic aw_ok, w_ok, got;
		m_aw[m] = '{addr: a, prot: 3'(draw()), valid: 1'b1};
		m_w[m]  = '{data: d, strb: st, valid: 1'b1};
		aw_ok = 1'b0;
		w_ok  = 1'b0;
		n     = 0;
		while (!(aw_ok && w_ok) && n < TIMEOUT) begin
			@(posedge aclk);
			if (m_aw[m].valid && m_awready[m]) aw_ok = 1'b1;
			if (m_w[m].valid && m_wready[m]) w_ok = 1'b1;
			#1;
			if (aw_ok) m_aw[m].valid = 1'b0;
			if (w_ok) m_w[m].valid = 1'b0;
			n++;
		end
		m_aw[m].valid = 1'b0;
		m_w[m].valid  = 1'b0;
		if (!(aw_ok && w_ok)) begin
			$display("master %0d: write to %h was not accepted in time", m, a);
			fails++;
			return;
		end
		got         = 1'b0;
		n           = 0;
		m_bready[m] = ready_draw(m);
		while (!got && n < TIMEOUT) begin
			@(posedge aclk);
			got = m_b[m].valid & m_bready[m];
			#1;
			m_bready[m] = got ? 1'b0 : ready_draw(m);
			n++;
		end
		m_bready[m] = 1'b0;
		if (!got) begin
			$display("master %0d: no write response for %h", m, a);
			fails++;
		end
	endtask

	task automatic do_read(input int m, input logic [63:0] a);
		int   n;
		logic ok;
		m_ar[m] = '{addr: a, prot: 3'(draw()), valid: 1'b1};
		ok = 1'b0;
		n  = 0;
		while (!ok && n < TIMEOUT) begin
			@(posedge aclk);
			ok = m_arready[m];
			#1;
			n++;
		end
		m_ar[m].valid = 1'b0;
		if (!ok) begin
			$display("master %0d: read of %h was not accepted in time", m, a);
			fails++;
			return;
		end
		ok          = 1'b0;
		n           = 0;
		m_rready[m] = ready_draw(m);
		while (!ok && n < TIMEOUT) begin
			@(posedge aclk);
			ok = m_r[m].valid & m_rready[m];
			#1;
			m_rready[m] = ok ? 1'b0 : ready_draw(m);
			n++;
		end
		m_rready[m] = 1'b0;
		if (!ok) begin
			$display("master %0d: no read data for %h", m, a);
			fails++;
		end
	endtask

	task automatic random_txn(input int m, input int s);
		logic [63:0] a;
		a = word_addr(s, m, int'(draw() % 8));
		if (draw() & 1)
			do_write(m, a, {draw(), draw()}, 8'(draw()));
		else
			do_read(m, a);
	endtask

	task automatic route_all(input int m);
		logic [63:0] a;
		for (int s = 0; s < `XBAR_NUM_S; s++) begin
			a = word_addr(s, m, s);
			do_write(m, a, {draw(), draw()}, 8'(draw()));
			do_read(m, a);
		end
	endtask

	task automatic unmapped_txn(input int m);
		do_write(m, 64'h1000_0000 + 64'(m * 8), {draw(), draw()}, 8'hFF);
		do_read(m, 64'h1000_0000 + 64'(m * 8));
		do_read(m, 64'h1_0000_0000 + 64'(m * 8));  // above the 32-bit map
	endtask

	task automatic random_run(input int m, input int count, input int s);
		repeat (count)
			random_txn(m, (s < 0) ? int'(draw() % 5) : s);
	endtask

	task automatic end_test(input string name);
		$display("test %-13s done, %0d errors so far", name, chk_errors + fails);
	endtask

	initial begin
		m_aw       = '0;
		m_w        = '0;
		m_ar       = '0;
		m_bready   = '0;
		m_rready   = '0;
		stall_ar   = '0;
		bp_en      = '0;
		err_phase  = 1'b0;
		rd_pending = 1'b0;
		fails      = 0;
		rnd        = 32'h8d0e41b5;
		rst_n      = 1'b0;
		repeat (5) @(posedge aclk);
		#1 rst_n = 1'b1;
		repeat (10) @(posedge aclk);
		#1;
		end_test("reset");

		fork
			route_all(0);
			route_all(1);
			route_all(2);
		join
		end_test("routing");

		err_phase = 1'b1;
		fork
			unmapped_txn(0);
			unmapped_txn(1);
			unmapped_txn(2);
		join
		repeat (3) @(posedge aclk);
		#1 err_phase = 1'b0;
		end_test("decode error");

		// all three at main memory
		fork
			random_run(0, 200, 4);
			random_run(1, 200, 4);
			random_run(2, 200, 4);
		join
		end_test("contention");

		bp_en = '1;
		fork
			random_run(0, 60, -1);
			random_run(1, 60, -1);
			random_run(2, 60, -1);
		join
		bp_en = '0;
		end_test("back-pressure");

		stall_ar[3] = 1'b1;
		fork
			begin
				rd_pending = 1'b1;
				do_read(0, word_addr(3, 0, 2));
				rd_pending = 1'b0;
			end
			begin
				repeat (3) @(posedge aclk);
				#1;
				fork
					do_write(0, word_addr(4, 0, 5), {draw(), draw()}, 8'hFF);
					do_write(1, word_addr(0, 1, 5), {draw(), draw()}, 8'h0F);
					do_write(2, word_addr(2, 2, 5), {draw(), draw()}, 8'hF0);
				join
				if (!rd_pending || !s_ar[3].valid) begin
					$display("independence: the read was not waiting at slave 3 when the writes finished");
					fails++;
				end
				stall_ar[3] = 1'b0;
			end
		join
		end_test("independence");

		repeat (5) @(posedge aclk);
		$display("summary: %0d checker errors, %0d other failures", chk_errors, fails);
		if (chk_errors == 0 && fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/xbar_checker.sv
// checker of the crossbar testbench, watches the ports and compares responses with a memory model
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_checker
	import xbar_pkg::*;
(
	input  logic                      aclk,
	input  logic                      rst_n,
	input  logic                      err_phase,  // only unmapped traffic while set
	input  axi_aw_t [`XBAR_NUM_M-1:0] m_aw,
	input  axi_w_t  [`XBAR_NUM_M-1:0] m_w,
	input  axi_ar_t [`XBAR_NUM_M-1:0] m_ar,
	input  logic    [`XBAR_NUM_M-1:0] m_bready,
	input  logic    [`XBAR_NUM_M-1:0] m_rready,
	input  logic    [`XBAR_NUM_M-1:0] m_awready,
	input  logic    [`XBAR_NUM_M-1:0] m_wready,
	input  logic    [`XBAR_NUM_M-1:0] m_arready,
	input  axi_b_t  [`XBAR_NUM_M-1:0] m_b,
	input  axi_r_t  [`XBAR_NUM_M-1:0] m_r,
	input  axi_aw_t [`XBAR_NUM_S-1:0] s_aw,
	input  axi_w_t  [`XBAR_NUM_S-1:0] s_w,
	input  axi_ar_t [`XBAR_NUM_S-1:0] s_ar,
	output int                        errors
);

	logic [63:0]            model [`XBAR_NUM_S][32];
	logic [63:0]            waddr [`XBAR_NUM_M];
	logic [63:0]            wdata [`XBAR_NUM_M];
	logic [7:0]             wstrb [`XBAR_NUM_M];
	logic [63:0]            raddr [`XBAR_NUM_M];
	logic [`XBAR_NUM_M-1:0] b_held, r_held;  // response seen valid but not taken
	axi_b_t                 b_prev [`XBAR_NUM_M];
	axi_r_t                 r_prev [`XBAR_NUM_M];
	logic                   req_seen;

	// 5 means no slave
	function automatic int region_of(input logic [63:0] a);
		if ((a & `XBAR_S0_MASK) == `XBAR_S0_BASE) return 0;
		if ((a & `XBAR_S1_MASK) == `XBAR_S1_BASE) return 1;
		if ((a & `XBAR_S2_MASK) == `XBAR_S2_BASE) return 2;
		if ((a & `XBAR_S3_MASK) == `XBAR_S3_BASE) return 3;
		if ((a & `XBAR_S4_MASK) == `XBAR_S4_BASE) return 4;
		return 5;
	endfunction

	task automatic report(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("Error %0t: %s expected %h actual %h", $time, name, exp, act);
		errors++;
	endtask

	// a forwarded request carries the address and prot of a master that is sending it
	task automatic check_forward(input string name, input axi_aw_t fwd,
	                             input axi_aw_t [`XBAR_NUM_M-1:0] src);
		logic hit;
		hit = 1'b0;
		for (int m = 0; m < `XBAR_NUM_M; m++)
			if (src[m].valid && src[m].addr == fwd.addr) begin
				hit = 1'b1;
				if (fwd.prot != src[m].prot)
					report({name, ".prot"}, 64'(src[m].prot), 64'(fwd.prot));
			end
		if (!hit) begin
			$display("Error %0t: %s carries an address that no master is sending", $time, name);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		for (int s = 0; s < `XBAR_NUM_S; s++)
			for (int i = 0; i < 32; i++)
				model[s][i] = {32'hC0DE_0000 | 32'(s), 32'hF00D_0000 | 32'(i)};
	end

	always @(posedge aclk) begin
		int          rg;
		axi_resp_e   er;
		logic [63:0] exp;
		if (!rst_n) begin
			req_seen = 1'b0;
			b_held   = '0;
			r_held   = '0;
		end else begin
			// quiet ports until the first request
			if (!req_seen) begin
				for (int s = 0; s < `XBAR_NUM_S; s++)
					if (s_aw[s].valid || s_w[s].valid || s_ar[s].valid)
						report($sformatf("slave %0d valid", s), 64'd0, 64'd1);
				for (int m = 0; m < `XBAR_NUM_M; m++)
					if (m_b[m].valid || m_r[m].valid)
						report($sformatf("master %0d response valid", m), 64'd0, 64'd1);
			end
			for (int m = 0; m < `XBAR_NUM_M; m++)
				if (m_aw[m].valid || m_w[m].valid || m_ar[m].valid)
					req_seen = 1'b1;
			if (err_phase)
				for (int s = 0; s < `XBAR_NUM_S; s++)
					if (s_aw[s].valid || s_w[s].valid || s_ar[s].valid) begin
						$display("Error %0t: slave %0d was handed a request for an unmapped address",
						         $time, s);
						errors++;
					end

			for (int s = 0; s < `XBAR_NUM_S; s++) begin
				if (s_aw[s].valid)
					check_forward($sformatf("s_aw[%0d]", s), s_aw[s], m_aw);
				if (s_ar[s].valid)
					check_forward($sformatf("s_ar[%0d]", s), s_ar[s], m_ar);
			end

			for (int m = 0; m < `XBAR_NUM_M; m++) begin
				// a stalled response must not move
				if (b_held[m]) begin
					if (!m_b[m].valid)
						report($sformatf("m_b[%0d].valid", m), 64'd1, 64'd0);
					else if (m_b[m].resp != b_prev[m].resp)
						report($sformatf("m_b[%0d].resp", m), 64'(b_prev[m].resp),
						       64'(m_b[m].resp));
				end
				if (r_held[m]) begin
					if (!m_r[m].valid)
						report($sformatf("m_r[%0d].valid", m), 64'd1, 64'd0);
					else if (m_r[m].data != r_prev[m].data)
						report($sformatf("m_r[%0d].data", m), r_prev[m].data, m_r[m].data);
					else if (m_r[m].resp != r_prev[m].resp)
						report($sformatf("m_r[%0d].resp", m), 64'(r_prev[m].resp),
						       64'(m_r[m].resp));
				end
				b_held[m] = m_b[m].valid & ~m_bready[m];
				r_held[m] = m_r[m].valid & ~m_rready[m];
				b_prev[m] = m_b[m];
				r_prev[m] = m_r[m];

				if (m_aw[m].valid && m_awready[m])
					waddr[m] = m_aw[m].addr;
				if (m_w[m].valid && m_wready[m]) begin
					wdata[m] = m_w[m].data;
					wstrb[m] = m_w[m].strb;
				end
				if (m_ar[m].valid && m_arready[m])
					raddr[m] = m_ar[m].addr;

				if (m_b[m].valid && m_bready[m]) begin
					rg = region_of(waddr[m]);
					er = (rg == 5) ? DECERR : OKAY;
					if (m_b[m].resp != er)
						report($sformatf("m_b[%0d].resp", m), 64'(er), 64'(m_b[m].resp));
					else if (rg != 5)
						for (int i = 0; i < 8; i++)
							if (wstrb[m][i])
								model[rg][waddr[m][7:3]][8*i +: 8] = wdata[m][8*i +: 8];
				end
				if (m_r[m].valid && m_rready[m]) begin
					rg  = region_of(raddr[m]);
					er  = (rg == 5) ? DECERR : OKAY;
					exp = (rg == 5) ? 64'h0 : model[rg][raddr[m][7:3]];
					if (m_r[m].resp != er)
						report($sformatf("m_r[%0d].resp", m), 64'(er), 64'(m_r[m].resp));
					if (m_r[m].data != exp)
						report($sformatf("m_r[%0d].data", m), exp, m_r[m].data);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/xbar_slave_model.sv
// memory-like axi4-lite slave for the crossbar testbench, random ready and response delays
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_slave_model
	import xbar_pkg::*;
#(
	parameter int SLV = 0
) (
	input  logic    aclk,
	input  logic    rst_n,
	input  logic    stall_ar,  // keeps arready low while set
	input  axi_aw_t aw,
	input  axi_w_t  w,
	input  axi_ar_t ar,
	input  logic    bready,
	input  logic    rready,
	output logic    awready,
	output logic    wready,
	output logic    arready,
	output axi_b_t  b,
	output axi_r_t  r
);

	logic [63:0] mem [32];
	logic [31:0] rnd;
	int          wst, wcnt, rdst, rcnt;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw_delay();
		rnd = xorshift(rnd);
		return int'(rnd[1:0]);  // 0 to 3 cycles
	endfunction

	initial begin
		logic   n_wrdy, n_ardy;
		axi_b_t n_b;
		axi_r_t n_r;
		for (int i = 0; i < 32; i++)
			mem[i] = {32'hC0DE_0000 | 32'(SLV), 32'hF00D_0000 | 32'(i)};
		rnd     = 32'h8d0e41b5 ^ (32'(SLV + 1) * 32'h9e37_79b9);
		awready = 1'b0;
		wready  = 1'b0;
		arready = 1'b0;
		b       = '0;
		r       = '0;
		wst     = 0;
		rdst    = 0;
		wcnt    = draw_delay();
		rcnt    = draw_delay();
		forever begin
			@(posedge aclk);
			n_wrdy = awready;
			n_ardy = arready;
			n_b    = b;
			n_r    = r;
			if (!rst_n) begin
				n_wrdy = 1'b0;
				n_ardy = 1'b0;
				n_b    = '0;
				n_r    = '0;
				wst    = 0;
				rdst   = 0;
			end else begin
				// write side
				case (wst)
					0: if (aw.valid && w.valid) begin
						if (wcnt == 0) begin
							n_wrdy = 1'b1;
							wst    = 1;
						end else wcnt--;
					end
					1: if (aw.valid && w.valid) begin  // ready is up, so this is the handshake
						for (int i = 0; i < 8; i++)
							if (w.strb[i])
								mem[aw.addr[7:3]][8*i +: 8] = w.data[8*i +: 8];
						n_wrdy = 1'b0;
						wcnt   = draw_delay();
						wst    = 2;
					end
					2: if (wcnt == 0) begin
						n_b = '{resp: OKAY, valid: 1'b1};
						wst = 3;
					end else wcnt--;
					default: if (bready) begin
						n_b  = '0;
						wcnt = draw_delay();
						wst  = 0;
					end
				endcase
				// read side
				case (rdst)
					0: if (ar.valid && !stall_ar) begin
						if (rcnt == 0) begin
							n_ardy = 1'b1;
							rdst   = 1;
						end else rcnt--;
					end
					1: if (ar.valid) begin
						n_r    = '{data: mem[ar.addr[7:3]], resp: OKAY, valid: 1'b0};
						n_ardy = 1'b0;
						rcnt   = draw_delay();
						rdst   = 2;
					end
					2: if (rcnt == 0) begin
						n_r.valid = 1'b1;
						rdst      = 3;
					end else rcnt--;
					default: if (rready) begin
						n_r  = '0;
						rcnt = draw_delay();
						rdst = 0;
					end
				endcase
			end
			#1;
			awready = n_wrdy;
			wready  = n_wrdy;
			arready = n_ardy;
			b       = n_b;
			r       = n_r;
		end
	end

endmodule

`default_nettype wire

//--- src/xbar_wrap.sv
// crossbar top level, connect the three core masters and the five slave ports of the soc here
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_wrap
	import xbar_pkg::*;
(
	input  logic                              aclk,
	input  logic                              rst_n,

	// master side: debug module, fetch, load/store
	input  axi_aw_t [`XBAR_NUM_M-1:0]         m_aw,
	input  axi_w_t  [`XBAR_NUM_M-1:0]         m_w,
	input  axi_ar_t [`XBAR_NUM_M-1:0]         m_ar,
	input  logic    [`XBAR_NUM_M-1:0]         m_bready,
	input  logic    [`XBAR_NUM_M-1:0]         m_rready,
	output logic    [`XBAR_NUM_M-1:0]         m_awready,
	output logic    [`XBAR_NUM_M-1:0]         m_wready,
	output logic    [`XBAR_NUM_M-1:0]         m_arready,
	output axi_b_t  [`XBAR_NUM_M-1:0]         m_b,
	output axi_r_t  [`XBAR_NUM_M-1:0]         m_r,

	// slave side: clint, plic, peripheral bus, system bus, memory
	output axi_aw_t [`XBAR_NUM_S-1:0]         s_aw,
	output axi_w_t  [`XBAR_NUM_S-1:0]         s_w,
	output axi_ar_t [`XBAR_NUM_S-1:0]         s_ar,
	output logic    [`XBAR_NUM_S-1:0]         s_bready,
	output logic    [`XBAR_NUM_S-1:0]         s_rready,
	input  logic    [`XBAR_NUM_S-1:0]         s_awready,
	input  logic    [`XBAR_NUM_S-1:0]         s_wready,
	input  logic    [`XBAR_NUM_S-1:0]         s_arready,
	input  axi_b_t  [`XBAR_NUM_S-1:0]         s_b,
	input  axi_r_t  [`XBAR_NUM_S-1:0]         s_r
);

	xbar_write_path i_wr (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.m_aw      (m_aw),
		.m_w       (m_w),
		.m_bready  (m_bready),
		.m_awready (m_awready),
		.m_wready  (m_wready),
		.m_b       (m_b),
		.s_aw      (s_aw),
		.s_w       (s_w),
		.s_bready  (s_bready),
		.s_awready (s_awready),
		.s_wready  (s_wready),
		.s_b       (s_b)
	);

	xbar_read_path i_rd (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.m_ar      (m_ar),
		.m_rready  (m_rready),
		.m_arready (m_arready),
		.m_r       (m_r),
		.s_ar      (s_ar),
		.s_rready  (s_rready),
		.s_arready (s_arready),
		.s_r       (s_r)
	);

endmodule

`default_nettype wire

//--- src/xbar_read_path.sv
// read half of the crossbar, routes ar and r and answers unmapped reads with decerr and zero data
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_read_path
	import xbar_pkg::*;
(
	input  logic                              aclk,
	input  logic                              rst_n,
	input  axi_ar_t [`XBAR_NUM_M-1:0]         m_ar,
	input  logic    [`XBAR_NUM_M-1:0]         m_rready,
	output logic    [`XBAR_NUM_M-1:0]         m_arready,
	output axi_r_t  [`XBAR_NUM_M-1:0]         m_r,
	output axi_ar_t [`XBAR_NUM_S-1:0]         s_ar,
	output logic    [`XBAR_NUM_S-1:0]         s_rready,
	input  logic    [`XBAR_NUM_S-1:0]         s_arready,
	input  axi_r_t  [`XBAR_NUM_S-1:0]         s_r
);

	logic [`XBAR_SEL_W-1:0]                    sel [`XBAR_NUM_M];
	logic [`XBAR_NUM_M-1:0]                    miss;
	logic [`XBAR_NUM_S-1:0][`XBAR_NUM_M-1:0]   req;
	logic [`XBAR_NUM_S-1:0][`XBAR_NUM_M-1:0]   gnt;
	logic [`XBAR_NUM_S-1:0]                    busy, done;
	logic [`XBAR_NUM_S-1:0]                    ar_done;
	logic [`XBAR_NUM_M-1:0]                    err_acc, err_rsp;

	for (genvar m = 0; m < `XBAR_NUM_M; m++) begin : g_dec
		xbar_addr_decode i_dec (
			.addr (m_ar[m].addr),
			.sel  (sel[m]),
			.miss (miss[m])
		);
	end

	for (genvar s = 0; s < `XBAR_NUM_S; s++) begin : g_arb
		xbar_rr_arbiter i_arb (
			.aclk  (aclk),
			.rst_n (rst_n),
			.req   (req[s]),
			.done  (done[s]),
			.grant (gnt[s]),
			.busy  (busy[s])
		);
	end

	always_comb begin
		for (int s = 0; s < `XBAR_NUM_S; s++)
			for (int m = 0; m < `XBAR_NUM_M; m++)
				req[s][m] = m_ar[m].valid & ~miss[m] & (sel[m] == `XBAR_SEL_W'(s));
	end

	always_comb begin
		s_ar      = '0;
		s_rready  = '0;
		m_arready = '0;
		m_r       = '0;
		for (int s = 0; s < `XBAR_NUM_S; s++) begin
			for (int m = 0; m < `XBAR_NUM_M; m++) begin
				if (gnt[s][m]) begin
					s_ar[s]       = m_ar[m];
					s_ar[s].valid = m_ar[m].valid & ~ar_done[s]; // only until taken
					s_rready[s]   = m_rready[m];
					m_arready[m]  = s_arready[s] & ~ar_done[s];
					m_r[m]        = s_r[s];
				end
			end
			done[s] = busy[s] & s_r[s].valid & s_rready[s];
		end
		for (int m = 0; m < `XBAR_NUM_M; m++) begin
			if (err_acc[m])
				m_arready[m] = 1'b1;
			if (err_rsp[m])
				m_r[m] = '{data: '0, resp: DECERR, valid: 1'b1};
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			ar_done <= '0;
			err_acc <= '0;
			err_rsp <= '0;
		end else begin
			for (int s = 0; s < `XBAR_NUM_S; s++) begin
				if (done[s])
					ar_done[s] <= 1'b0;
				else if (s_ar[s].valid && s_arready[s])
					ar_done[s] <= 1'b1;
			end
			for (int m = 0; m < `XBAR_NUM_M; m++) begin
				err_acc[m] <= m_ar[m].valid & miss[m] & ~err_acc[m] & ~err_rsp[m];
				if (err_acc[m])
					err_rsp[m] <= 1'b1;
				else if (m_rready[m])
					err_rsp[m] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/xbar_write_path.sv
// write half of the crossbar, routes aw, w and b and answers unmapped writes with decerr
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_write_path
	import xbar_pkg::*;
(
	input  logic                              aclk,
	input  logic                              rst_n,
	input  axi_aw_t [`XBAR_NUM_M-1:0]         m_aw,
	input  axi_w_t  [`XBAR_NUM_M-1:0]         m_w,
	input  logic    [`XBAR_NUM_M-1:0]         m_bready,
	output logic    [`XBAR_NUM_M-1:0]         m_awready,
	output logic    [`XBAR_NUM_M-1:0]         m_wready,
	output axi_b_t  [`XBAR_NUM_M-1:0]         m_b,
	output axi_aw_t [`XBAR_NUM_S-1:0]         s_aw,
	output axi_w_t  [`XBAR_NUM_S-1:0]         s_w,
	output logic    [`XBAR_NUM_S-1:0]         s_bready,
	input  logic    [`XBAR_NUM_S-1:0]         s_awready,
	input  logic    [`XBAR_NUM_S-1:0]         s_wready,
	input  axi_b_t  [`XBAR_NUM_S-1:0]         s_b
);

	logic [`XBAR_SEL_W-1:0]                    sel [`XBAR_NUM_M];
	logic [`XBAR_NUM_M-1:0]                    miss;
	logic [`XBAR_NUM_S-1:0][`XBAR_NUM_M-1:0]   req;
	logic [`XBAR_NUM_S-1:0][`XBAR_NUM_M-1:0]   gnt;
	logic [`XBAR_NUM_S-1:0]                    busy, done;
	logic [`XBAR_NUM_S-1:0]                    aw_done, w_done; // channel already taken
	logic [`XBAR_NUM_M-1:0]                    err_acc, err_rsp;

	for (genvar m = 0; m < `XBAR_NUM_M; m++) begin : g_dec
		xbar_addr_decode i_dec (
			.addr (m_aw[m].addr),
			.sel  (sel[m]),
			.miss (miss[m])
		);
	end

	for (genvar s = 0; s < `XBAR_NUM_S; s++) begin : g_arb
		xbar_rr_arbiter i_arb (
			.aclk  (aclk),
			.rst_n (rst_n),
			.req   (req[s]),
			.done  (done[s]),
			.grant (gnt[s]),
			.busy  (busy[s])
		);
	end

	//////////////////////////////////////////////////
	// request and routing

	always_comb begin
		for (int s = 0; s < `XBAR_NUM_S; s++)
			for (int m = 0; m < `XBAR_NUM_M; m++)
				req[s][m] = m_aw[m].valid & m_w[m].valid & ~miss[m] &
				            (sel[m] == `XBAR_SEL_W'(s));
	end

	always_comb begin
		s_aw      = '0;
		s_w       = '0;
		s_bready  = '0;
		m_awready = '0;
		m_wready  = '0;
		m_b       = '0;
		for (int s = 0; s < `XBAR_NUM_S; s++) begin
			for (int m = 0; m < `XBAR_NUM_M; m++) begin
				if (gnt[s][m]) begin
					s_aw[s]       = m_aw[m];
					s_aw[s].valid = m_aw[m].valid & ~aw_done[s];
					s_w[s]        = m_w[m];
					s_w[s].valid  = m_w[m].valid & ~w_done[s];
					s_bready[s]   = m_bready[m];
					m_awready[m]  = s_awready[s] & ~aw_done[s];
					m_wready[m]   = s_wready[s] & ~w_done[s];
					m_b[m]        = s_b[s];
				end
			end
			done[s] = busy[s] & s_b[s].valid & s_bready[s];
		end
		// unmapped writes
		for (int m = 0; m < `XBAR_NUM_M; m++) begin
			if (err_acc[m]) begin
				m_awready[m] = 1'b1;
				m_wready[m]  = 1'b1;
			end
			if (err_rsp[m])
				m_b[m] = '{resp: DECERR, valid: 1'b1};
		end
	end

	//////////////////////////////////////////////////
	// per-grant state and error responder

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			aw_done <= '0;
			w_done  <= '0;
			err_acc <= '0;
			err_rsp <= '0;
		end else begin
			for (int s = 0; s < `XBAR_NUM_S; s++) begin
				if (done[s]) begin
					aw_done[s] <= 1'b0;
					w_done[s]  <= 1'b0;
				end else begin
					if (s_aw[s].valid && s_awready[s])
						aw_done[s] <= 1'b1;
					if (s_w[s].valid && s_wready[s])
						w_done[s] <= 1'b1;
				end
			end
			for (int m = 0; m < `XBAR_NUM_M; m++) begin
				// pair is taken in the cycle err_acc is high
				err_acc[m] <= m_aw[m].valid & m_w[m].valid & miss[m] & ~err_acc[m] & ~err_rsp[m];
				if (err_acc[m])
					err_rsp[m] <= 1'b1;
				else if (m_bready[m])
					err_rsp[m] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/xbar_rr_arbiter.sv
// round-robin arbiter for one slave channel pair, grant is registered and held until done
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_rr_arbiter (
	input  logic                   aclk,
	input  logic                   rst_n,
	input  logic [`XBAR_NUM_M-1:0] req,
	input  logic                   done,   // response handshake of the granted master
	output logic [`XBAR_NUM_M-1:0] grant,  // one-hot
	output logic                   busy
);

	localparam int PW = $clog2(`XBAR_NUM_M);

	logic [PW-1:0]          ptr;  // master with top priority
	logic [`XBAR_NUM_M-1:0] pick;
	logic [PW-1:0]          next_ptr;

	// walk down from the lowest priority so the highest one is written last
	always_comb begin
		int idx;
		pick = '0;
		for (int i = `XBAR_NUM_M - 1; i >= 0; i--) begin
			idx = (int'(ptr) + i) % `XBAR_NUM_M;
			if (req[idx]) begin
				pick      = '0;
				pick[idx] = 1'b1;
			end
		end
	end

	always_comb begin
		next_ptr = ptr;
		for (int i = 0; i < `XBAR_NUM_M; i++)
			if (grant[i])
				next_ptr = PW'((i + 1) % `XBAR_NUM_M); // just past the winner
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= '0;
			ptr   <= '0;   // debug module first
		end else if (busy) begin
			if (done) begin
				grant <= '0;
				ptr   <= next_ptr;
			end
		end else begin
			grant <= pick;
		end
	end

	assign busy = |grant;

endmodule

`default_nettype wire

//--- src/xbar_addr_decode.sv
// address decoder of the crossbar, one per master and channel, gives the target slave or a miss
`default_nettype none
`timescale 1ns/1ps

`include "xbar_settings.svh"

module xbar_addr_decode (
	input  logic [`XBAR_ADDR_W-1:0] addr,
	output logic [`XBAR_SEL_W-1:0]  sel,
	output logic                    miss
);

	localparam logic [`XBAR_ADDR_W-1:0] BASE [`XBAR_NUM_S] = '{
		`XBAR_S0_BASE, `XBAR_S1_BASE, `XBAR_S2_BASE, `XBAR_S3_BASE, `XBAR_S4_BASE
	};
	localparam logic [`XBAR_ADDR_W-1:0] MASK [`XBAR_NUM_S] = '{
		`XBAR_S0_MASK, `XBAR_S1_MASK, `XBAR_S2_MASK, `XBAR_S3_MASK, `XBAR_S4_MASK
	};

	// regions do not overlap, so at most one compare hits
	always_comb begin
		sel  = '0;
		miss = 1'b1;
		for (int s = 0; s < `XBAR_NUM_S; s++) begin
			if ((addr & MASK[s]) == BASE[s]) begin
				sel  = `XBAR_SEL_W'(s);
				miss = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/xbar_pkg.sv
// axi4-lite channel structs and response codes, import into any module that carries the channels
`default_nettype none

`include "xbar_settings.svh"

package xbar_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		DECERR = 2'b11
	} axi_resp_e;

	//////////////////////////////////////////////////
	// request channels, driven toward the slave

	typedef struct packed {
		logic [`XBAR_ADDR_W-1:0] addr;
		logic [2:0]              prot;  // passed through untouched
		logic                    valid;
	} axi_aw_t;

	typedef struct packed {
		logic [`XBAR_DATA_W-1:0] data;
		logic [`XBAR_STRB_W-1:0] strb;
		logic                    valid;
	} axi_w_t;

	typedef axi_aw_t axi_ar_t; // same fields as aw

	//////////////////////////////////////////////////
	// response channels, driven toward the master

	typedef struct packed {
		axi_resp_e resp;
		logic      valid;
	} axi_b_t;

	typedef struct packed {
		logic [`XBAR_DATA_W-1:0] data;
		axi_resp_e               resp;
		logic                    valid;
	} axi_r_t;

endpackage

`default_nettype wire

//--- src/xbar_settings.svh
// widths, port counts and address map of the crossbar, include wherever these macros are needed
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

`define XBAR_ADDR_W 64
`define XBAR_DATA_W 64
`define XBAR_STRB_W 8
`define XBAR_NUM_M  3   // debug module, fetch, load/store
`define XBAR_NUM_S  5
`define XBAR_SEL_W  3   // wide enough for a slave index

// slave regions, hit when (addr & mask) == base
`define XBAR_S0_BASE 64'h0000_0000_0200_0000 // clint, 64 KiB
`define XBAR_S0_MASK 64'hFFFF_FFFF_FFFF_0000
`define XBAR_S1_BASE 64'h0000_0000_0C00_0000 // plic, 64 MiB
`define XBAR_S1_MASK 64'hFFFF_FFFF_FC00_0000
`define XBAR_S2_BASE 64'h0000_0000_2000_0000 // peripheral bus, 256 MiB
`define XBAR_S2_MASK 64'hFFFF_FFFF_F000_0000
`define XBAR_S3_BASE 64'h0000_0000_4000_0000 // system bus, 1 GiB
`define XBAR_S3_MASK 64'hFFFF_FFFF_C000_0000
`define XBAR_S4_BASE 64'h0000_0000_8000_0000 // memory, up to the top of the 32-bit space
`define XBAR_S4_MASK 64'hFFFF_FFFF_8000_0000

`endif
